// File: baud_tick_gen.sv
`timescale 1ns/1ps

module baud_tick_gen #(
   parameter int CLKS_PER_TICK = 4
) (
   input  logic clk,
   input  logic reset,
   output logic tick
);

   localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_TICK - 1);

   logic [CNT_W-1:0] cnt;

   // free running divider, restarts on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt  <= '0;
         tick <= 1'b0;
      end else begin
         if (cnt == CNT_LAST) begin
            cnt <= '0;
         end else begin
            cnt <= cnt + 1'b1;
         end
         // one clock wide pulse per wrap
         tick <= (cnt == CNT_LAST);
      end
   end

endmodule

// File: byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if;
   import echo_pkg::*;

   byte_t data;
   // stop bit of this frame sampled low
   logic frame_err;
   logic valid;
   logic ready;

   modport source (
      output data,
      output frame_err,
      output valid,
      input  ready
   );

   modport sink (
      input  data,
      input  frame_err,
      input  valid,
      output ready
   );

endinterface

// File: echo_fifo.sv
`timescale 1ns/1ps

module echo_fifo #(
   parameter int FIFO_DEPTH = 16
) (
   input  logic                clk,
   input  logic                reset,
   byte_stream_if.sink         rx_stream,
   byte_stream_if.source       tx_stream,
   output echo_pkg::err_count_t rx_err_count
);
   import echo_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);
   localparam logic [AW:0] FULL_COUNT = (AW + 1)'(FIFO_DEPTH);

   byte_t         mem [FIFO_DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          accept;
   logic          push;
   logic          pop;

   assign rx_stream.ready = (count != FULL_COUNT);
   assign accept = rx_stream.valid && rx_stream.ready;
   // flagged frames are taken but never stored
   assign push = accept && !rx_stream.frame_err;
   assign pop  = tx_stream.valid && tx_stream.ready;

   assign tx_stream.valid     = (count != '0);
   assign tx_stream.data      = mem[rd_ptr];
   assign tx_stream.frame_err = 1'b0;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= rx_stream.data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         count        <= '0;
         rx_err_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // saturating drop counter
         if (accept && rx_stream.frame_err && (rx_err_count != '1)) begin
            rx_err_count <= rx_err_count + 1'b1;
         end
      end
   end

endmodule

// File: echo_pkg.sv
package echo_pkg;

   // one data byte of the echo path
   typedef logic [7:0] byte_t;

   // dropped frame count, saturates at all ones
   typedef logic [7:0] err_count_t;

endpackage

// File: filelist.f
uart_line_pkg.sv
echo_pkg.sv
byte_stream_if.sv
baud_tick_gen.sv
uart_rx.sv
uart_tx.sv
echo_fifo.sv
uart_echo_top.sv
tb_serial_peer.sv
tb_uart_echo.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the uart echo testbench with verilator, run it and judge the log

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=sim_uart_echo
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module tb_uart_echo \
   -Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^TB PASSED$" "$LOG_FILE"; then
   echo "simulation passed, log in $LOG_FILE"
   exit 0
else
   echo "pass line not found in $LOG_FILE"
   exit 1
fi

// File: tb_serial_peer.sv
`timescale 1ns/1ps

module tb_serial_peer #(
   parameter int CLKS_PER_TICK = 4
) (
   input  logic                 clk,
   output logic                 rx,
   input  logic                 tx,
   output echo_pkg::err_count_t expected_errors,
   output int                   bytes_received,
   output int                   bytes_pending,
   output logic                 check_failed
);
   import uart_line_pkg::*;
   import echo_pkg::*;

   localparam int BIT_CLKS   = CLKS_PER_TICK * OVERSAMPLE;
   localparam int HALF_BIT   = BIT_CLKS / 2;
   localparam int FRAME_BITS = DATA_BITS + 2;

   // every frame handed to the peer, with its stop bit level
   byte_t frame_data [$];
   logic  frame_stop_ok [$];
   int    next_frame;
   byte_t expect_q [$];
   byte_t echo_q [$];
   string test_name;

   initial begin
      rx              = 1'b1;
      expected_errors = '0;
      bytes_pending   = 0;
      check_failed    = 1'b0;
      next_frame      = 0;
      test_name       = "reset";
   end

   function automatic void queue_frame(input byte_t data, input logic stop_ok);
      frame_data.push_back(data);
      frame_stop_ok.push_back(stop_ok);
   endfunction

   // good frames echo in order, frames with a low stop bit only count
   function automatic void expected_echo(input int first);
      for (int i = first; i < frame_data.size(); i++) begin
         if (frame_stop_ok[i]) begin
            expect_q.push_back(frame_data[i]);
         end else if (expected_errors != 8'hff) begin
            expected_errors = expected_errors + 8'd1;
         end
      end
      bytes_pending = expect_q.size();
   endfunction

   // one 8N1 frame, lsb first, called on a falling clock edge
   task automatic send_frame(input byte_t data, input logic stop_ok);
      logic [FRAME_BITS-1:0] bits;
      bits = {stop_ok, data, 1'b0};
      for (int i = 0; i < FRAME_BITS; i++) begin
         rx   = bits[0];
         bits = bits >> 1;
         repeat (BIT_CLKS) @(negedge clk);
      end
      // line has to go high again before the next start edge
      if (!stop_ok) begin
         rx = 1'b1;
         repeat (BIT_CLKS) @(negedge clk);
      end
   endtask

   task automatic send_queued(input string name, input int gap_clks);
      int last;
      test_name = name;
      last      = frame_data.size();
      expected_echo(next_frame);
      for (int i = next_frame; i < last; i++) begin
         send_frame(frame_data[i], frame_stop_ok[i]);
         repeat (gap_clks) @(negedge clk);
      end
      next_frame = last;
   endtask

   task automatic send_glitch(input string name, input int low_clks);
      test_name = name;
      rx        = 1'b0;
      repeat (low_clks) @(negedge clk);
      rx = 1'b1;
   endtask

   task automatic wait_for_echoes();
      while (bytes_pending != 0) begin
         @(negedge clk);
      end
      // let the last stop bit finish
      repeat (BIT_CLKS) @(negedge clk);
   endtask

   // decode frames coming back on tx
   initial begin : receive_echoes
      byte_t shifted;
      shifted        = '0;
      bytes_received = 0;
      forever begin
         @(negedge tx);
         repeat (HALF_BIT) @(negedge clk);
         assert (tx === 1'b0) else begin
            $display("start bit on tx was high again at its middle in test %s", test_name);
            check_failed = 1'b1;
         end
         for (int i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            shifted = {tx, shifted[DATA_BITS-1:1]};
         end
         repeat (BIT_CLKS) @(negedge clk);
         assert (tx === 1'b1) else begin
            $display("stop bit on tx sampled low in test %s", test_name);
            check_failed = 1'b1;
         end
         echo_q.push_back(shifted);
         bytes_received = bytes_received + 1;
      end
   end

   initial begin : compare_echoes
      byte_t got;
      byte_t want;
      forever begin
         @(negedge clk);
         while (echo_q.size() > 0) begin
            got = echo_q.pop_front();
            assert (expect_q.size() != 0) else begin
               $display("echo byte 0x%02h arrived in test %s with nothing left to echo",
                        got, test_name);
               check_failed = 1'b1;
            end
            if (expect_q.size() != 0) begin
               want          = expect_q.pop_front();
               bytes_pending = expect_q.size();
               assert (got == want) else begin
                  $display("[FAIL] %s: expected 0x%02h, got 0x%02h", test_name, want, got);
                  check_failed = 1'b1;
               end
            end
         end
      end
   end

endmodule

// File: tb_uart_echo.sv
`timescale 1ns/1ps

module tb_uart_echo;
   import uart_line_pkg::*;
   import echo_pkg::*;

   localparam int CLKS_PER_TICK   = 4;
   localparam int FIFO_DEPTH      = 16;
   localparam int BIT_CLKS        = CLKS_PER_TICK * OVERSAMPLE;
   localparam int FRAME_CLKS      = BIT_CLKS * (DATA_BITS + 2);
   localparam int IDLE_CLKS       = 2000;
   localparam int GREETING_FRAMES = 9;
   localparam int RANDOM_FRAMES   = 40;
   localparam int MIXED_FRAMES    = 10;
   localparam int TOTAL_FRAMES    = GREETING_FRAMES + RANDOM_FRAMES + MIXED_FRAMES;
   // two and a half frame times for each frame sent
   localparam int TIMEOUT_CYCLES  = TOTAL_FRAMES * FRAME_CLKS * 5 / 2 + 2000;

   // byte 0 in the low bits and stop bit levels in the same order
   localparam logic [MIXED_FRAMES*8-1:0] MIXED_DATA = 80'h3c_c3_7e_81_f0_0f_5a_a5_ff_00;
   localparam logic [MIXED_FRAMES-1:0]   MIXED_STOP_OK = 10'b1011011011;

   logic        clk;
   logic        reset;
   logic        rx;
   logic        tx;
   err_count_t  rx_err_count;
   err_count_t  expected_errors;
   int          bytes_received;
   int          bytes_pending;
   logic        peer_failed;
   logic [31:0] lfsr_state;
   int          cycle_count = 0;

   uart_echo_top #(
      .CLKS_PER_TICK (CLKS_PER_TICK),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) dut (
      .clk          (clk),
      .reset        (reset),
      .rx           (rx),
      .tx           (tx),
      .rx_err_count (rx_err_count)
   );

   tb_serial_peer #(
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) peer (
      .clk             (clk),
      .rx              (rx),
      .tx              (tx),
      .expected_errors (expected_errors),
      .bytes_received  (bytes_received),
      .bytes_pending   (bytes_pending),
      .check_failed    (peer_failed)
   );

   always #10 clk = ~clk;

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   // galois form, x^32 + x^31 + x^29 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] next;
      next = state >> 1;
      if (state[0]) begin
         next = next ^ 32'hd000_0001;
      end
      return next;
   endfunction

   task automatic next_random_byte(output byte_t value);
      value = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value      = {lfsr_state[0], value[7:1]};
      end
   endtask

   task automatic check_err_count(input string name);
      assert (rx_err_count == expected_errors) else stop_with_error(
         $sformatf("[FAIL] %s: expected rx_err_count %0d, got %0d",
                   name, expected_errors, rx_err_count));
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      assert (cycle_count < TIMEOUT_CYCLES) else stop_with_error(
         $sformatf("timeout: the echo never completed within %0d cycles", TIMEOUT_CYCLES));
   end

   always @(posedge peer_failed) begin
      stop_with_error("the serial peer found a wrong echo on tx");
   end

   initial begin
      string                     greeting;
      byte_t                     value;
      logic [MIXED_FRAMES*8-1:0] mixed_data;
      logic [MIXED_FRAMES-1:0]   mixed_ok;
      int                        before_glitch;

      clk        = 1'b0;
      reset      = 1'b1;
      lfsr_state = 32'h8e79_cb23;
      greeting   = "AGH WFiIS";
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // idle line after reset
      for (int i = 0; i < IDLE_CLKS; i++) begin
         @(negedge clk);
         assert (tx === 1'b1) else stop_with_error(
            $sformatf("[FAIL] idle: expected tx 1, got %b", tx));
      end
      assert (bytes_received == 0) else stop_with_error(
         $sformatf("[FAIL] idle: expected 0 echo bytes, got %0d", bytes_received));
      check_err_count("idle");

      // greeting with three idle bits between frames
      for (int i = 0; i < greeting.len(); i++) begin
         peer.queue_frame(greeting[i], 1'b1);
      end
      peer.send_queued("greeting", 3 * BIT_CLKS);
      peer.wait_for_echoes();
      check_err_count("greeting");

      // back to back frames while echoes wait in the fifo
      for (int i = 0; i < RANDOM_FRAMES; i++) begin
         next_random_byte(value);
         peer.queue_frame(value, 1'b1);
      end
      peer.send_queued("random", 0);
      peer.wait_for_echoes();
      check_err_count("random");

      mixed_data = MIXED_DATA;
      mixed_ok   = MIXED_STOP_OK;
      for (int i = 0; i < MIXED_FRAMES; i++) begin
         peer.queue_frame(mixed_data[7:0], mixed_ok[0]);
         mixed_data = mixed_data >> 8;
         mixed_ok   = mixed_ok >> 1;
      end
      peer.send_queued("mixed", 0);
      peer.wait_for_echoes();
      check_err_count("mixed");

      // short low pulse must be rejected at the start bit middle
      before_glitch = bytes_received;
      peer.send_glitch("glitch", 5);
      repeat (2 * FRAME_CLKS) @(negedge clk);
      assert (bytes_received == before_glitch) else stop_with_error(
         $sformatf("[FAIL] glitch: expected %0d echo bytes, got %0d",
                   before_glitch, bytes_received));
      check_err_count("glitch");

      if (bytes_pending == 0 &&
          bytes_received == GREETING_FRAMES + RANDOM_FRAMES + $countones(MIXED_STOP_OK)) begin
         $display("TB PASSED");
         $finish;
      end else begin
         stop_with_error($sformatf("run ended with %0d echo bytes still missing, %0d received",
                                   bytes_pending, bytes_received));
      end
   end

endmodule

// File: uart_echo_top.sv
`timescale 1ns/1ps

module uart_echo_top #(
   parameter int CLKS_PER_TICK = 4,
   parameter int FIFO_DEPTH    = 16
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 rx,
   output logic                 tx,
   output echo_pkg::err_count_t rx_err_count
);

   logic tick;

   // receiver to fifo, fifo to transmitter
   byte_stream_if rx_stream ();
   byte_stream_if tx_stream ();

   baud_tick_gen #(
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) u_baud_tick_gen (
      .clk   (clk),
      .reset (reset),
      .tick  (tick)
   );

   uart_rx u_uart_rx (
      .clk       (clk),
      .reset     (reset),
      .tick      (tick),
      .rx        (rx),
      .rx_stream (rx_stream.source)
   );

   echo_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_echo_fifo (
      .clk          (clk),
      .reset        (reset),
      .rx_stream    (rx_stream.sink),
      .tx_stream    (tx_stream.source),
      .rx_err_count (rx_err_count)
   );

   uart_tx u_uart_tx (
      .clk       (clk),
      .reset     (reset),
      .tick      (tick),
      .tx        (tx),
      .tx_stream (tx_stream.sink)
   );

endmodule

// File: uart_line_pkg.sv
package uart_line_pkg;

   // serial line framing, 8N1 with no parity

   // oversampling ticks per bit period
   localparam int OVERSAMPLE = 16;

   // data bits carried by one frame, sent lsb first
   localparam int DATA_BITS = 8;

   // tick index of the bit middle, counted from the start edge
   localparam int SAMPLE_MID = 7;

endpackage

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
   input  logic           clk,
   input  logic           reset,
   input  logic           tick,
   input  logic           rx,
   byte_stream_if.source  rx_stream
);
   import uart_line_pkg::*;
   import echo_pkg::*;

   localparam int TICK_W = $clog2(OVERSAMPLE);
   localparam int BIT_W  = $clog2(DATA_BITS);

   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
   localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(SAMPLE_MID);
   localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(DATA_BITS - 1);

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_START = 2'd1;
   localparam logic [1:0] S_DATA  = 2'd2;
   localparam logic [1:0] S_STOP  = 2'd3;

   logic              rx_meta;
   logic              rx_sync;
   logic              rx_prev;
   logic [1:0]        state;
   logic [TICK_W-1:0] tick_cnt;
   logic [BIT_W-1:0]  bit_cnt;
   byte_t             shift_reg;

   // two flop synchronizer, line idles high
   always_ff @(posedge clk) begin
      if (reset) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state           <= S_IDLE;
         tick_cnt        <= '0;
         bit_cnt         <= '0;
         rx_stream.valid <= 1'b0;
      end else begin
         // held byte leaves on the handshake
         if (rx_stream.valid && rx_stream.ready) begin
            rx_stream.valid <= 1'b0;
         end

         case (state)
            S_IDLE: begin
               // falling edge starts a candidate frame
               if (rx_prev && !rx_sync) begin
                  tick_cnt <= '0;
                  state    <= S_START;
               end
            end

            S_START: begin
               if (tick) begin
                  if (tick_cnt == TICK_MID) begin
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     // line back high at mid start means a glitch
                     state    <= rx_sync ? S_IDLE : S_DATA;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end

            S_DATA: begin
               if (tick) begin
                  if (tick_cnt == TICK_LAST) begin
                     tick_cnt  <= '0;
                     // lsb arrives first
                     shift_reg <= {rx_sync, shift_reg[DATA_BITS-1:1]};
                     if (bit_cnt == BIT_LAST) begin
                        state <= S_STOP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end

            S_STOP: begin
               if (tick) begin
                  if (tick_cnt == TICK_LAST) begin
                     tick_cnt            <= '0;
                     rx_stream.data      <= shift_reg;
                     rx_stream.frame_err <= !rx_sync;
                     rx_stream.valid     <= 1'b1;
                     state               <= S_IDLE;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end

            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
   input  logic          clk,
   input  logic          reset,
   input  logic          tick,
   output logic          tx,
   byte_stream_if.sink   tx_stream
);
   import uart_line_pkg::*;

   // start bit, data bits, stop bit
   localparam int FRAME_BITS = DATA_BITS + 2;
   localparam int TICK_W     = $clog2(OVERSAMPLE);
   localparam int BIT_W      = $clog2(FRAME_BITS);

   localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
   localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(FRAME_BITS - 1);

   logic                  busy;
   logic [FRAME_BITS-1:0] frame;
   logic [TICK_W-1:0]     tick_cnt;
   logic [BIT_W-1:0]      bit_cnt;

   assign tx_stream.ready = !busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         busy     <= 1'b0;
         tx       <= 1'b1;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else if (!busy) begin
         if (tx_stream.valid) begin
            frame    <= {1'b1, tx_stream.data, 1'b0};
            busy     <= 1'b1;
            tick_cnt <= '0;
            bit_cnt  <= '0;
         end
      end else if (tick) begin
         // new bit goes out on the first tick of its period
         if (tick_cnt == '0) begin
            tx    <= frame[0];
            frame <= {1'b1, frame[FRAME_BITS-1:1]};
         end
         if (tick_cnt == TICK_LAST) begin
            tick_cnt <= '0;
            // done after the full stop bit, line stays high
            if (bit_cnt == BIT_LAST) begin
               busy <= 1'b0;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

endmodule
